// File: common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and pc width
`define CORE_XLEN        32
// register index width, 32 registers
`define CORE_REG_ADDR_W  5
// jal writes its link value here
`define CORE_LINK_REG    31
// link value is pc plus this
`define CORE_LINK_OFFSET 8

// primary opcodes, instr[31:26]
`define CORE_OP_SPECIAL  6'b000000
`define CORE_OP_JAL      6'b000011
`define CORE_OP_BEQ      6'b000100
`define CORE_OP_BNE      6'b000101
`define CORE_OP_ADDI     6'b001000
`define CORE_OP_ADDIU    6'b001001
`define CORE_OP_SLTI     6'b001010
`define CORE_OP_SLTIU    6'b001011
`define CORE_OP_ANDI     6'b001100
`define CORE_OP_ORI      6'b001101
`define CORE_OP_XORI     6'b001110
`define CORE_OP_LUI      6'b001111

// funct field of SPECIAL, instr[5:0]
`define CORE_FN_SLL      6'b000000
`define CORE_FN_SRL      6'b000010
`define CORE_FN_SRA      6'b000011
`define CORE_FN_SLLV     6'b000100
`define CORE_FN_SRLV     6'b000110
`define CORE_FN_SRAV     6'b000111
`define CORE_FN_JR       6'b001000
`define CORE_FN_ADD      6'b100000
`define CORE_FN_ADDU     6'b100001
`define CORE_FN_SUB      6'b100010
`define CORE_FN_SUBU     6'b100011
`define CORE_FN_AND      6'b100100
`define CORE_FN_OR       6'b100101
`define CORE_FN_XOR      6'b100110
`define CORE_FN_NOR      6'b100111
`define CORE_FN_SLT      6'b101010
`define CORE_FN_SLTU     6'b101011

`endif

// File: common/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    // register-register format
    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`CORE_REG_ADDR_W-1:0] rs;
        logic [`CORE_REG_ADDR_W-1:0] rt;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [4:0]                  sa;
        logic [5:0]                  funct;
    } r_fmt_t;

    // immediate format, also beq/bne
    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`CORE_REG_ADDR_W-1:0] rs;
        logic [`CORE_REG_ADDR_W-1:0] rt;
        logic [15:0]                 imm;
    } i_fmt_t;

    // jump format, only jal kept
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    // one code per alu function
    // add also covers addu, addi, addiu and the jal link
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    // operand a source
    // sa form is the shift amount for constant shifts
    typedef enum logic [1:0] {
        OPA_RS,
        OPA_PC,
        OPA_SA
    } opa_sel_t;

    // operand b source
    typedef enum logic [1:0] {
        OPB_RT,
        OPB_SIMM,
        OPB_ZIMM,
        OPB_LINK
    } opb_sel_t;

    // destination register field
    typedef enum logic [1:0] {
        DST_RD,
        DST_RT,
        DST_LINK
    } dst_sel_t;

endpackage

// File: decode/reg_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
    input  logic                        clk,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr1,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr2,
    input  logic                        we,
    input  logic [`CORE_REG_ADDR_W-1:0] waddr,
    input  logic [`CORE_XLEN-1:0]       wdata,
    output logic [`CORE_XLEN-1:0]       rdata1,
    output logic [`CORE_XLEN-1:0]       rdata2
);

    // r0 has no storage, only r1..r31
    logic [`CORE_XLEN-1:0] regs [1:31];

    // single write port
    // writes aimed at r0 are dropped here as well
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read
    // r0 always reads zero
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: decode/inst_decode.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_decode import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  logic [`CORE_XLEN-1:0]       inst,
    input  logic [`CORE_XLEN-1:0]       pc,
    input  logic                        fwd_we,
    input  logic [`CORE_REG_ADDR_W-1:0] fwd_addr,
    input  logic [`CORE_XLEN-1:0]       fwd_data,
    input  logic                        wb_valid,
    input  logic [`CORE_REG_ADDR_W-1:0] wb_addr,
    input  logic [`CORE_XLEN-1:0]       wb_data,
    output logic                        br_taken,
    output logic [`CORE_XLEN-1:0]       br_target,
    output logic                        ex_valid,
    output alu_op_t                     ex_op,
    output logic [`CORE_XLEN-1:0]       ex_opa,
    output logic [`CORE_XLEN-1:0]       ex_opb,
    output logic                        ex_we,
    output logic [`CORE_REG_ADDR_W-1:0] ex_dst
);

    logic                        id_valid;
    instr_t                      id_inst;
    logic [`CORE_XLEN-1:0]       id_pc;
    logic [`CORE_XLEN-1:0]       rf_rdata1;
    logic [`CORE_XLEN-1:0]       rf_rdata2;
    logic [`CORE_XLEN-1:0]       rs_val;
    logic [`CORE_XLEN-1:0]       rt_val;
    logic [`CORE_XLEN-1:0]       pc_plus_4;
    logic [`CORE_XLEN-1:0]       opa;
    logic [`CORE_XLEN-1:0]       opb;
    logic [`CORE_REG_ADDR_W-1:0] dst;
    alu_op_t                     dec_op;
    opa_sel_t                    opa_sel;
    opb_sel_t                    opb_sel;
    dst_sel_t                    dst_sel;
    logic                        dec_wr;
    logic                        is_beq;
    logic                        is_bne;
    logic                        is_jr;
    logic                        is_jal;

    // pick the newest value of a source register
    // execute beats writeback beats the register file, r0 never forwarded
    function automatic logic [`CORE_XLEN-1:0] fwd_pick(
        input logic [`CORE_REG_ADDR_W-1:0] src,
        input logic [`CORE_XLEN-1:0]       rf_val
    );
        if (src == '0) begin
            return '0;
        end else if (fwd_we && (fwd_addr == src)) begin
            return fwd_data;
        end else if (wb_valid && (wb_addr == src)) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    // decode register, only the valid flag is reset
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            id_inst <= inst;
            id_pc   <= pc;
        end
    end

    // writeback outputs drive the write port directly
    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (id_inst.r.rs),
        .raddr2 (id_inst.r.rt),
        .we     (wb_valid),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    always_comb begin
        rs_val = fwd_pick(id_inst.r.rs, rf_rdata1);
        rt_val = fwd_pick(id_inst.r.rt, rf_rdata2);
    end

    // opcode and funct to alu op, operand and destination selects
    always_comb begin
        dec_op  = ALU_ADD;
        opa_sel = OPA_RS;
        opb_sel = OPB_RT;
        dst_sel = DST_RD;
        dec_wr  = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jr   = 1'b0;
        is_jal  = 1'b0;
        case (id_inst.r.opcode)
            `CORE_OP_SPECIAL: begin
                dec_wr = 1'b1;
                case (id_inst.r.funct)
                    // no overflow trap, add behaves as addu
                    `CORE_FN_ADD, `CORE_FN_ADDU: dec_op = ALU_ADD;
                    `CORE_FN_SUB, `CORE_FN_SUBU: dec_op = ALU_SUB;
                    `CORE_FN_SLT:  dec_op = ALU_SLT;
                    `CORE_FN_SLTU: dec_op = ALU_SLTU;
                    `CORE_FN_AND:  dec_op = ALU_AND;
                    `CORE_FN_OR:   dec_op = ALU_OR;
                    `CORE_FN_XOR:  dec_op = ALU_XOR;
                    `CORE_FN_NOR:  dec_op = ALU_NOR;
                    // constant shifts take sa as operand a
                    `CORE_FN_SLL: begin
                        dec_op  = ALU_SLL;
                        opa_sel = OPA_SA;
                    end
                    `CORE_FN_SRL: begin
                        dec_op  = ALU_SRL;
                        opa_sel = OPA_SA;
                    end
                    `CORE_FN_SRA: begin
                        dec_op  = ALU_SRA;
                        opa_sel = OPA_SA;
                    end
                    `CORE_FN_SLLV: dec_op = ALU_SLL;
                    `CORE_FN_SRLV: dec_op = ALU_SRL;
                    `CORE_FN_SRAV: dec_op = ALU_SRA;
                    `CORE_FN_JR: begin
                        dec_wr = 1'b0;
                        is_jr  = 1'b1;
                    end
                    default: dec_wr = 1'b0;
                endcase
            end
            `CORE_OP_ADDI, `CORE_OP_ADDIU: begin
                opb_sel = OPB_SIMM;
                dst_sel = DST_RT;
                dec_wr  = 1'b1;
            end
            `CORE_OP_SLTI, `CORE_OP_SLTIU: begin
                // both sign-extend, sltiu compares unsigned
                dec_op  = (id_inst.r.opcode == `CORE_OP_SLTI) ? ALU_SLT : ALU_SLTU;
                opb_sel = OPB_SIMM;
                dst_sel = DST_RT;
                dec_wr  = 1'b1;
            end
            `CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI, `CORE_OP_LUI: begin
                case (id_inst.r.opcode)
                    `CORE_OP_ANDI: dec_op = ALU_AND;
                    `CORE_OP_ORI:  dec_op = ALU_OR;
                    `CORE_OP_XORI: dec_op = ALU_XOR;
                    default:       dec_op = ALU_LUI;
                endcase
                opb_sel = OPB_ZIMM;
                dst_sel = DST_RT;
                dec_wr  = 1'b1;
            end
            `CORE_OP_BEQ: is_beq = 1'b1;
            `CORE_OP_BNE: is_bne = 1'b1;
            // link is pc + 8 through the adder
            `CORE_OP_JAL: begin
                is_jal  = 1'b1;
                opa_sel = OPA_PC;
                opb_sel = OPB_LINK;
                dst_sel = DST_LINK;
                dec_wr  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opa_sel)
            OPA_PC:  opa = id_pc;
            OPA_SA:  opa = {{(`CORE_XLEN-5){1'b0}}, id_inst.r.sa};
            default: opa = rs_val;
        endcase
        case (opb_sel)
            OPB_SIMM: opb = {{(`CORE_XLEN-16){id_inst.i.imm[15]}}, id_inst.i.imm};
            OPB_ZIMM: opb = {{(`CORE_XLEN-16){1'b0}}, id_inst.i.imm};
            OPB_LINK: opb = `CORE_XLEN'(`CORE_LINK_OFFSET);
            default:  opb = rt_val;
        endcase
        case (dst_sel)
            DST_RT:   dst = id_inst.r.rt;
            DST_LINK: dst = `CORE_REG_ADDR_W'(`CORE_LINK_REG);
            default:  dst = id_inst.r.rd;
        endcase
    end

    // branch resolution on forwarded operands
    assign pc_plus_4 = id_pc + `CORE_XLEN'(4);
    assign br_taken  = id_valid & ((is_beq & (rs_val == rt_val)) |
                                   (is_bne & (rs_val != rt_val)) | is_jr | is_jal);

    always_comb begin
        if (is_jr) begin
            br_target = rs_val;
        end else if (is_jal) begin
            br_target = {pc_plus_4[31:28], id_inst.j.index, 2'b00};
        end else begin
            br_target = pc_plus_4 + {{(`CORE_XLEN-18){id_inst.i.imm[15]}},
                                     id_inst.i.imm, 2'b00};
        end
    end

    // decode to execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            // r0 destination never writes
            ex_we    <= id_valid & dec_wr & (dst != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_op  <= dec_op;
            ex_opa <= opa;
            ex_opb <= opb;
            ex_dst <= dst;
        end
    end

endmodule

// File: logic/alu_execute.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module alu_execute import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ex_valid,
    input  alu_op_t                     ex_op,
    input  logic [`CORE_XLEN-1:0]       ex_opa,
    input  logic [`CORE_XLEN-1:0]       ex_opb,
    input  logic                        ex_we,
    input  logic [`CORE_REG_ADDR_W-1:0] ex_dst,
    output logic                        fwd_we,
    output logic [`CORE_REG_ADDR_W-1:0] fwd_addr,
    output logic [`CORE_XLEN-1:0]       fwd_data,
    output logic                        wb_valid,
    output logic [`CORE_REG_ADDR_W-1:0] wb_addr,
    output logic [`CORE_XLEN-1:0]       wb_data
);

    logic [`CORE_XLEN-1:0] alu_res;
    logic [4:0]            shamt;
    logic                  ex_wr;

    // shift amount from low five bits of operand a
    // sa for constant shifts, rs for variable ones
    assign shamt = ex_opa[4:0];

    // only a valid instruction with a nonzero destination writes
    assign ex_wr = ex_valid & ex_we;

    always_comb begin
        case (ex_op)
            ALU_ADD: begin
                alu_res = ex_opa + ex_opb;
            end
            ALU_SUB: begin
                alu_res = ex_opa - ex_opb;
            end
            // signed compare
            ALU_SLT: begin
                alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(ex_opa) < $signed(ex_opb)};
            end
            // unsigned compare, sltiu arrives sign-extended
            ALU_SLTU: begin
                alu_res = {{(`CORE_XLEN-1){1'b0}}, ex_opa < ex_opb};
            end
            ALU_AND: begin
                alu_res = ex_opa & ex_opb;
            end
            ALU_NOR: begin
                alu_res = ~(ex_opa | ex_opb);
            end
            ALU_OR: begin
                alu_res = ex_opa | ex_opb;
            end
            ALU_XOR: begin
                alu_res = ex_opa ^ ex_opb;
            end
            // shifts act on operand b
            ALU_SLL: begin
                alu_res = ex_opb << shamt;
            end
            ALU_SRL: begin
                alu_res = ex_opb >> shamt;
            end
            ALU_SRA: begin
                alu_res = $signed(ex_opb) >>> shamt;
            end
            // immediate into the upper half
            ALU_LUI: begin
                alu_res = {ex_opb[15:0], 16'b0};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // combinational bypass to decode, one instruction behind
    assign fwd_we   = ex_wr;
    assign fwd_addr = ex_dst;
    assign fwd_data = alu_res;

    // writeback register
    // the flag is a one-cycle pulse per writing instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_wr;
        end
    end

    // address and data move only on a write
    always_ff @(posedge clk) begin
        if (ex_wr) begin
            wb_addr <= ex_dst;
            wb_data <= alu_res;
        end
    end

endmodule

// File: logic/core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  logic [`CORE_XLEN-1:0]       inst,
    input  logic [`CORE_XLEN-1:0]       pc,
    output logic                        br_taken,
    output logic [`CORE_XLEN-1:0]       br_target,
    output logic                        wb_valid,
    output logic [`CORE_REG_ADDR_W-1:0] wb_addr,
    output logic [`CORE_XLEN-1:0]       wb_data
);

    // decode to execute
    logic                        ex_valid;
    alu_op_t                     ex_op;
    logic [`CORE_XLEN-1:0]       ex_opa;
    logic [`CORE_XLEN-1:0]       ex_opb;
    logic                        ex_we;
    logic [`CORE_REG_ADDR_W-1:0] ex_dst;

    // execute bypass back to decode
    logic                        fwd_we;
    logic [`CORE_REG_ADDR_W-1:0] fwd_addr;
    logic [`CORE_XLEN-1:0]       fwd_data;

    // decode stage, holds the register file
    // writeback outputs loop back as forward source and write port
    inst_decode u_inst_decode (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .fwd_we     (fwd_we),
        .fwd_addr   (fwd_addr),
        .fwd_data   (fwd_data),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_opa     (ex_opa),
        .ex_opb     (ex_opb),
        .ex_we      (ex_we),
        .ex_dst     (ex_dst)
    );

    // alu plus writeback register
    alu_execute u_alu_execute (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_opa   (ex_opa),
        .ex_opb   (ex_opb),
        .ex_we    (ex_we),
        .ex_dst   (ex_dst),
        .fwd_we   (fwd_we),
        .fwd_addr (fwd_addr),
        .fwd_data (fwd_data),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

// File: testbench/core_checker.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        inst_valid,
    input logic                        br_taken,
    input logic [`CORE_XLEN-1:0]       br_target,
    input logic                        wb_valid,
    input logic [`CORE_REG_ADDR_W-1:0] wb_addr
);

    // failed assertions, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // nothing leaves the pipeline in the cycle after a reset cycle
    a_quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!wb_valid && !br_taken)
    ) else begin
        $error("wb_valid or br_taken high right after reset");
        fail_cnt++;
    end

    // fixed latency, three edges from strobe to writeback
    a_wb_latency: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> $past(inst_valid, 3)
    ) else begin
        $error("wb_valid without an instruction three cycles earlier");
        fail_cnt++;
    end

    // r0 writes are suppressed before writeback
    a_wb_not_r0: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> (wb_addr != '0)
    ) else begin
        $error("writeback to r0");
        fail_cnt++;
    end

    // targets are word aligned
    a_target_aligned: assert property (
        @(posedge clk) disable iff (rst) br_taken |-> (br_target[1:0] == 2'b00)
    ) else begin
        $error("taken branch target not word aligned");
        fail_cnt++;
    end

    // a branch can only resolve with an instruction in decode
    a_taken_needs_inst: assert property (
        @(posedge clk) disable iff (rst) br_taken |-> $past(inst_valid)
    ) else begin
        $error("br_taken with an empty decode stage");
        fail_cnt++;
    end

endmodule

// File: testbench/core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb import core_pkg::*;;

    // rounded-up count of instructions issued over all tests
    localparam int N_INSTS        = 380;
    localparam int TIMEOUT_CYCLES = 16 + 2 * N_INSTS + 20;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        br_taken;
    logic [31:0] br_target;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // reference register state where r0 is never written
    logic [31:0] model_regs [32];
    // expected writes {addr, data} and decode outcomes {taken, target}
    logic [36:0] wq [$];
    logic [32:0] bq [$];

    logic [31:0] cur_pc;
    logic        dec_slot;
    int unsigned cycle_cnt;
    int          checks;
    int          errors;
    int          mark_checks;
    int          mark_errors;

    logic [5:0] alu_fns [10] = '{`CORE_FN_ADD, `CORE_FN_ADDU, `CORE_FN_SUB, `CORE_FN_SUBU,
                                 `CORE_FN_SLT, `CORE_FN_SLTU, `CORE_FN_AND, `CORE_FN_OR,
                                 `CORE_FN_XOR, `CORE_FN_NOR};
    logic [5:0] shift_fns [6] = '{`CORE_FN_SLL, `CORE_FN_SRL, `CORE_FN_SRA,
                                  `CORE_FN_SLLV, `CORE_FN_SRLV, `CORE_FN_SRAV};
    logic [5:0] imm_ops [8] = '{`CORE_OP_ADDI, `CORE_OP_ADDIU, `CORE_OP_SLTI, `CORE_OP_SLTIU,
                                `CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI, `CORE_OP_LUI};

    core_top u_core_top (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    bind core_top core_checker u_core_checker (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // mirrors the decode valid flag
    always @(posedge clk) begin
        dec_slot <= rst ? 1'b0 : inst_valid;
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn,
                                          input logic [4:0] rs, rt, rd, sa);
        return {`CORE_OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [25:0] index);
        return {`CORE_OP_JAL, index};
    endfunction

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // architectural effect of one instruction in program order
    task automatic model_exec(input logic [31:0] word, input logic [31:0] ipc);
        instr_t      w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic [31:0] tgt;
        logic [31:0] pc4;
        logic [4:0]  dst;
        logic        wr;
        logic        taken;
        w     = word;
        a     = model_regs[w.r.rs];
        b     = model_regs[w.r.rt];
        simm  = {{16{w.i.imm[15]}}, w.i.imm};
        zimm  = {16'h0000, w.i.imm};
        pc4   = ipc + 32'd4;
        res   = '0;
        tgt   = '0;
        dst   = w.i.rt;
        wr    = 1'b1;
        taken = 1'b0;
        case (w.r.opcode)
            `CORE_OP_SPECIAL: begin
                dst = w.r.rd;
                case (w.r.funct)
                    `CORE_FN_ADD, `CORE_FN_ADDU: res = a + b;
                    `CORE_FN_SUB, `CORE_FN_SUBU: res = a - b;
                    `CORE_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `CORE_FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    `CORE_FN_AND:  res = a & b;
                    `CORE_FN_OR:   res = a | b;
                    `CORE_FN_XOR:  res = a ^ b;
                    `CORE_FN_NOR:  res = ~(a | b);
                    `CORE_FN_SLL:  res = b << w.r.sa;
                    `CORE_FN_SRL:  res = b >> w.r.sa;
                    `CORE_FN_SRA:  res = $signed(b) >>> w.r.sa;
                    `CORE_FN_SLLV: res = b << a[4:0];
                    `CORE_FN_SRLV: res = b >> a[4:0];
                    `CORE_FN_SRAV: res = $signed(b) >>> a[4:0];
                    `CORE_FN_JR: begin
                        wr    = 1'b0;
                        taken = 1'b1;
                        tgt   = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            `CORE_OP_ADDI, `CORE_OP_ADDIU: res = a + simm;
            `CORE_OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            `CORE_OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
            `CORE_OP_ANDI:  res = a & zimm;
            `CORE_OP_ORI:   res = a | zimm;
            `CORE_OP_XORI:  res = a ^ zimm;
            `CORE_OP_LUI:   res = {w.i.imm, 16'h0000};
            `CORE_OP_BEQ, `CORE_OP_BNE: begin
                wr    = 1'b0;
                taken = (w.r.opcode == `CORE_OP_BEQ) ? (a == b) : (a != b);
                tgt   = pc4 + (simm << 2);
            end
            `CORE_OP_JAL: begin
                dst   = 5'd31;
                res   = ipc + 32'd8;
                taken = 1'b1;
                tgt   = {pc4[31:28], w.j.index, 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && (dst != 5'd0)) begin
            model_regs[dst] = res;
            wq.push_back({dst, res});
        end
        bq.push_back({taken, tgt});
    endtask

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        pc         <= cur_pc;
        model_exec(word, cur_pc);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic bubble(input int n);
        repeat (n) begin
            @(posedge clk);
            inst_valid <= 1'b0;
        end
    endtask

    // idle until every expected write and branch outcome was seen
    task automatic drain_pipe();
        bubble(1);
        while ((wq.size() != 0) || (bq.size() != 0)) begin
            @(posedge clk);
        end
        bubble(1);
    endtask

    task automatic end_test(input string name);
        drain_pipe();
        $display("%-10s done: %0d checks, %0d mismatches", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin : monitor
        logic [36:0] wexp;
        logic [32:0] bexp;
        if (!rst) begin
            if (wb_valid) begin
                if (wq.size() == 0) begin
                    $display("writeback to r%0d arrived with no write pending", wb_addr);
                    errors++;
                end else begin
                    wexp = wq.pop_front();
                    check_hex("wb_addr", 32'(wexp[36:32]), 32'(wb_addr));
                    check_hex("wb_data", wexp[31:0], wb_data);
                end
            end
            if (dec_slot && (bq.size() != 0)) begin
                bexp = bq.pop_front();
                check_hex("br_taken", 32'(bexp[32]), 32'(br_taken));
                if (bexp[32]) begin
                    check_hex("br_target", bexp[31:0], br_target);
                end
            end else begin
                check_hex("br_taken", 32'd0, 32'(br_taken));
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, pipeline never drained", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        logic [4:0]  src;
        logic [15:0] imm;
        int          sel;
        int          assert_fails;
        void'($urandom(70));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        cur_pc     = 32'h0000_1000;
        cycle_cnt  = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // full 32-bit values everywhere and r31 word aligned for jr
        for (int r = 1; r < 32; r++) begin
            issue(enc_i(`CORE_OP_LUI, 5'd0, 5'(r), 16'($urandom)));
            imm = (r == 31) ? 16'h0100 : 16'($urandom);
            issue(enc_i(`CORE_OP_ORI, 5'(r), 5'(r), imm));
        end
        end_test("reg_init");

        for (int n = 0; n < 20; n++) begin
            issue(enc_r(alu_fns[n % 10], 5'($urandom_range(1, 31)),
                        5'($urandom_range(1, 31)), 5'($urandom_range(1, 30)), 5'd0));
        end
        end_test("r_type");

        // second round forces a negative immediate
        for (int n = 0; n < 16; n++) begin
            imm = 16'($urandom);
            imm[15] = (n >= 8);
            issue(enc_i(imm_ops[n % 8], 5'($urandom_range(1, 31)),
                        5'($urandom_range(1, 30)), imm));
        end
        end_test("immediate");

        for (int n = 0; n < 12; n++) begin
            issue(enc_r(shift_fns[n % 6], 5'($urandom_range(1, 31)),
                        5'($urandom_range(1, 31)), 5'($urandom_range(1, 30)),
                        5'($urandom_range(0, 31))));
        end
        end_test("shift");

        // chains at distance 1..3 back to back and then spaced
        for (int gap = 0; gap <= 3; gap += 3) begin
            for (int d = 1; d <= 3; d++) begin
                for (int k = 0; k < 6; k++) begin
                    src = (k < d) ? 5'd1 : 5'(10 + k - d);
                    issue(enc_r(`CORE_FN_ADDU, src, 5'd2, 5'(10 + k), 5'd0));
                    bubble(gap);
                end
            end
        end
        // execute result must win over writeback for the same register
        issue(enc_i(`CORE_OP_ADDIU, 5'd0, 5'd20, 16'h0001));
        issue(enc_i(`CORE_OP_ADDIU, 5'd0, 5'd20, 16'h0002));
        issue(enc_r(`CORE_FN_ADDU, 5'd20, 5'd20, 5'd21, 5'd0));
        end_test("forward");

        issue(enc_i(`CORE_OP_ADDIU, 5'd0, 5'd7, 16'h0005));
        issue(enc_i(`CORE_OP_ADDIU, 5'd0, 5'd8, 16'h0005));
        issue(enc_i(`CORE_OP_BEQ, 5'd7, 5'd8, 16'h0010));
        issue(enc_i(`CORE_OP_BNE, 5'd7, 5'd8, 16'hfff0));
        issue(enc_i(`CORE_OP_ADDIU, 5'd0, 5'd8, 16'hffff));
        issue(enc_i(`CORE_OP_BEQ, 5'd7, 5'd8, 16'h0004));
        issue(enc_i(`CORE_OP_BNE, 5'd8, 5'd7, 16'hff00));
        issue(enc_j(26'h0123456));
        // link forwarded straight from execute
        issue(enc_r(`CORE_FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
        bubble(3);
        issue(enc_r(`CORE_FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
        issue(enc_i(`CORE_OP_BEQ, 5'd0, 5'd0, 16'h0008));
        end_test("branch");

        issue(enc_r(`CORE_FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(enc_i(`CORE_OP_ORI, 5'd3, 5'd0, 16'hbeef));
        issue(enc_i(`CORE_OP_LUI, 5'd0, 5'd0, 16'h1234));
        issue(enc_r(`CORE_FN_OR, 5'd0, 5'd1, 5'd9, 5'd0));
        issue(enc_r(`CORE_FN_ADDU, 5'd0, 5'd0, 5'd9, 5'd0));
        issue(enc_i(`CORE_OP_SLTIU, 5'd0, 5'd9, 16'h0001));
        end_test("r0");

        // destinations stay below r31 so jr r31 always sees a link value
        for (int n = 0; n < 200; n++) begin
            sel = $urandom_range(0, 9);
            case (sel)
                0, 1, 2: issue(enc_r(alu_fns[$urandom_range(0, 9)], 5'($urandom),
                                     5'($urandom), 5'($urandom_range(0, 30)), 5'd0));
                3: issue(enc_r(shift_fns[$urandom_range(0, 5)], 5'($urandom), 5'($urandom),
                               5'($urandom_range(0, 30)), 5'($urandom)));
                4, 5: issue(enc_i(imm_ops[$urandom_range(0, 7)], 5'($urandom),
                                  5'($urandom_range(0, 30)), 16'($urandom)));
                6: issue(enc_i(`CORE_OP_BEQ, 5'($urandom), 5'($urandom), 16'($urandom)));
                7: issue(enc_i(`CORE_OP_BNE, 5'($urandom), 5'($urandom), 16'($urandom)));
                8: issue(enc_j(26'($urandom)));
                default: issue(enc_r(`CORE_FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
            endcase
        end
        end_test("random");

        assert_fails = u_core_top.u_core_checker.fail_cnt;
        $display("%0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/core_pkg.sv
decode/reg_file.sv
decode/inst_decode.sv
logic/alu_execute.sv
logic/core_top.sv
testbench/core_checker.sv
testbench/core_tb.sv
